// ==== run.sh ====
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f src.f --top-module tbMipsControl -o simMipsControl
./obj_dir/simMipsControl | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
exit 0

// ==== src.f ====
+incdir+src
src/ctrlPkg.sv
src/opDecoder.sv
src/cycleSequencer.sv
src/controlWordGen.sv
src/mipsControl.sv
test/tbMipsControl.sv

// ==== src/controlWordGen.sv ====
`timescale 1ns/1ps

module controlWordGen import ctrlPkg::*; (
    input  ctrlState_t state,
    output logic       PCWrite,
    output logic       PCWriteCond,
    output logic       IRWrite,
    output logic       MemReadWrite,
    output logic       RegWrite,
    output logic       RegALoad,
    output logic       RegBLoad,
    output logic       ALUSrcA,      // 0 pc, 1 reg A
    output logic       EPCWrite,
    output logic       ALUOSrc,      // 1 selects the slt flag
    output logic       ALUOutWrite,
    output logic       MDRLoad,
    output logic       HiLoWrite,
    output logic       multInit,
    output regDst_t    RegDst,
    output memToReg_t  MemtoReg,
    output aluSrcB_t   ALUSrcB,
    output iOrD_t      IorD,
    output aluOp_t     ALUOp,
    output pcSrc_t     PCSrc,
    output eqOrNe_t    EqOrNe
);

    always_comb begin
        PCWrite      = 1'b0;
        PCWriteCond  = 1'b0;
        IRWrite      = 1'b0;
        MemReadWrite = 1'b0;
        RegWrite     = 1'b0;
        RegALoad     = 1'b0;
        RegBLoad     = 1'b0;
        ALUSrcA      = 1'b0;
        EPCWrite     = 1'b0;
        ALUOSrc      = 1'b0;
        ALUOutWrite  = 1'b0;
        MDRLoad      = 1'b0;
        HiLoWrite    = 1'b0;
        multInit     = 1'b0;
        RegDst       = DST_RT;
        MemtoReg     = WB_ALU;
        ALUSrcB      = SRCB_REG;
        IorD         = ADDR_PC;
        ALUOp        = ALU_PASS_A;
        PCSrc        = PC_ALU;
        EqOrNe       = CMP_NONE;

        case (state)
            RESET_INIT: begin
                RegWrite = 1'b1;
                RegDst   = DST_SP;
                MemtoReg = WB_SP_INIT;
            end
            FETCH: begin
                PCWrite = 1'b1; // pc <= pc + 4, memory takes the old pc
                ALUSrcB = SRCB_FOUR;
                ALUOp   = ALU_ADD;
            end
            IR_LOAD: IRWrite = 1'b1;
            DECODE: begin
                RegALoad    = 1'b1;
                RegBLoad    = 1'b1;
                ALUSrcB     = SRCB_BR_OFF; // branch target, kept in ALUOut
                ALUOp       = ALU_ADD;
                ALUOutWrite = 1'b1;
            end
            ADD_EXEC, AND_EXEC, SUB_EXEC, SLT_EXEC,
            ADDI_EXEC, ADDIU_EXEC, SLTI_EXEC, MEM_ADDR: begin
                ALUSrcA     = 1'b1;
                ALUOutWrite = 1'b1;
                case (state)
                    AND_EXEC:  ALUOp = ALU_AND;
                    SUB_EXEC:  ALUOp = ALU_SUB;
                    SLT_EXEC:  ALUOp = ALU_CMP;
                    SLTI_EXEC: ALUOp = ALU_CMP;
                    default:   ALUOp = ALU_ADD;
                endcase
                if (state == SLT_EXEC || state == SLTI_EXEC) begin
                    ALUOSrc = 1'b1;
                end
                if (state inside {ADDI_EXEC, ADDIU_EXEC, SLTI_EXEC, MEM_ADDR}) begin
                    ALUSrcB = SRCB_IMM;
                end
            end
            RTYPE_WB: begin
                RegWrite = 1'b1;
                RegDst   = DST_RD;
            end
            IMM_WB: RegWrite = 1'b1;
            MEM_READ: IorD = ADDR_ALUOUT; // address sampled here
            MDR_LOAD: MDRLoad = 1'b1;
            LW_WB: begin
                RegWrite = 1'b1;
                MemtoReg = WB_MEM;
            end
            SW_WRITE: begin
                IorD         = ADDR_ALUOUT;
                MemReadWrite = 1'b1;
            end
            BEQ_EXEC, BNE_EXEC: begin
                ALUSrcA     = 1'b1;
                ALUOp       = ALU_SUB;
                PCSrc       = PC_ALUOUT;
                PCWriteCond = 1'b1;
                EqOrNe      = (state == BEQ_EXEC) ? CMP_EQ : CMP_NE;
            end
            JAL_LINK: begin
                RegWrite = 1'b1;
                RegDst   = DST_RA;
                MemtoReg = WB_LINK;
            end
            JUMP: begin
                PCSrc   = PC_JUMP;
                PCWrite = 1'b1;
            end
            JR_EXEC: begin
                ALUSrcA = 1'b1;
                PCWrite = 1'b1;
            end
            EXC_OVF, EXC_BAD: begin
                ALUSrcB  = SRCB_FOUR; // epc <= pc - 4
                ALUOp    = ALU_SUB;
                EPCWrite = 1'b1;
                IorD     = (state == EXC_OVF) ? ADDR_VEC_OVF : ADDR_VEC_BAD;
            end
            EXC_VEC_READ: MDRLoad = 1'b1;
            EXC_JUMP: begin
                PCSrc   = PC_MDR;
                PCWrite = 1'b1;
            end
            MULT_START: multInit = 1'b1;
            MULT_DONE:  HiLoWrite = 1'b1;
            default: ; // FETCH_WAIT, MEM_WAIT, EXC_WAIT, MULT_WAIT idle
        endcase
    end

endmodule

// ==== src/ctrlPkg.sv ====
package ctrlPkg;

    // one class per supported instruction
    typedef enum logic [4:0] {
        CLS_ADD,
        CLS_AND,
        CLS_SUB,
        CLS_SLT,
        CLS_ADDI,
        CLS_ADDIU,
        CLS_SLTI,
        CLS_LW,
        CLS_SW,
        CLS_BEQ,
        CLS_BNE,
        CLS_J,
        CLS_JAL,
        CLS_JR,
        CLS_MULT,
        CLS_INVALID
    } instrClass_t;

    typedef enum logic [5:0] {
        RESET_INIT,
        FETCH,
        FETCH_WAIT,
        IR_LOAD,
        DECODE,
        ADD_EXEC,
        AND_EXEC,
        SUB_EXEC,
        SLT_EXEC,
        RTYPE_WB,
        ADDI_EXEC,
        ADDIU_EXEC,
        SLTI_EXEC,
        IMM_WB,
        MEM_ADDR,
        MEM_READ,
        MEM_WAIT,
        MDR_LOAD,
        LW_WB,
        SW_WRITE,
        BEQ_EXEC,
        BNE_EXEC,
        JUMP,
        JAL_LINK,
        JR_EXEC,
        EXC_OVF,
        EXC_BAD,
        EXC_WAIT,
        EXC_VEC_READ,
        EXC_JUMP,
        MULT_START,
        MULT_WAIT,
        MULT_DONE
    } ctrlState_t;

    // datapath mux encodings
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA, DST_SP} regDst_t;

    typedef enum logic [3:0] {
        WB_ALU     = 4'd0,
        WB_MEM     = 4'd1,
        WB_LINK    = 4'd6, // pc of the next instruction
        WB_SP_INIT = 4'd7
    } memToReg_t;

    typedef enum logic [2:0] {
        ALU_PASS_A = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_AND    = 3'd3,
        ALU_CMP    = 3'd7
    } aluOp_t;

    typedef enum logic [1:0] {SRCB_REG, SRCB_FOUR, SRCB_IMM, SRCB_BR_OFF} aluSrcB_t;
    typedef enum logic [2:0] {ADDR_PC, ADDR_ALUOUT, ADDR_VEC_BAD, ADDR_VEC_OVF} iOrD_t;
    typedef enum logic [2:0] {PC_ALU, PC_ALUOUT, PC_JUMP, PC_MDR} pcSrc_t;
    typedef enum logic [1:0] {CMP_NONE, CMP_NE, CMP_EQ} eqOrNe_t;

endpackage

// ==== src/ctrl_cfg.svh ====
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// instruction field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH  6

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0a
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct codes, only looked at under OP_RTYPE
`define FN_JR   6'h08
`define FN_MULT 6'h18
`define FN_ADD  6'h20
`define FN_SUB  6'h22
`define FN_AND  6'h24
`define FN_SLT  6'h2a

// the multiplier needs this many cycles after multInit
// before hi/lo are valid
`define MULT_CYCLES    33

// wide enough to hold MULT_CYCLES - 1
`define MULT_CNT_WIDTH 6

`endif

// ==== src/cycleSequencer.sv ====
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module cycleSequencer import ctrlPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  instrClass_t instrClass,
    input  logic        overflow,
    output ctrlState_t  state
);

    // counter runs from this value down to zero inside MULT_WAIT
    localparam int unsigned MULT_LOAD = `MULT_CYCLES - 1;

    ctrlState_t                 stateNext;
    logic [`MULT_CNT_WIDTH-1:0] multCnt;

    always_comb begin
        stateNext = state;
        case (state)
            RESET_INIT: stateNext = FETCH;
            FETCH:      stateNext = FETCH_WAIT;
            FETCH_WAIT: stateNext = IR_LOAD;
            IR_LOAD:    stateNext = DECODE;

            DECODE: begin
                case (instrClass)
                    CLS_ADD:   stateNext = ADD_EXEC;
                    CLS_AND:   stateNext = AND_EXEC;
                    CLS_SUB:   stateNext = SUB_EXEC;
                    CLS_SLT:   stateNext = SLT_EXEC;
                    CLS_ADDI:  stateNext = ADDI_EXEC;
                    CLS_ADDIU: stateNext = ADDIU_EXEC;
                    CLS_SLTI:  stateNext = SLTI_EXEC;
                    CLS_LW:    stateNext = MEM_ADDR;
                    CLS_SW:    stateNext = MEM_ADDR;
                    CLS_BEQ:   stateNext = BEQ_EXEC;
                    CLS_BNE:   stateNext = BNE_EXEC;
                    CLS_J:     stateNext = JUMP;
                    CLS_JAL:   stateNext = JAL_LINK;
                    CLS_JR:    stateNext = JR_EXEC;
                    CLS_MULT:  stateNext = MULT_START;
                    default:   stateNext = EXC_BAD;
                endcase
            end

            // signed arithmetic, may trap
            ADD_EXEC,
            SUB_EXEC: stateNext = overflow ? EXC_OVF : RTYPE_WB;
            ADDI_EXEC: stateNext = overflow ? EXC_OVF : IMM_WB;

            AND_EXEC,
            SLT_EXEC:   stateNext = RTYPE_WB;
            ADDIU_EXEC,
            SLTI_EXEC:  stateNext = IMM_WB;
            RTYPE_WB,
            IMM_WB:     stateNext = FETCH;

            MEM_ADDR: stateNext = (instrClass == CLS_SW) ? SW_WRITE : MEM_READ;
            MEM_READ: stateNext = MEM_WAIT;
            MEM_WAIT: stateNext = MDR_LOAD;
            MDR_LOAD: stateNext = LW_WB;
            LW_WB,
            SW_WRITE: stateNext = FETCH;

            BEQ_EXEC,
            BNE_EXEC,
            JR_EXEC,
            JUMP:     stateNext = FETCH;
            JAL_LINK: stateNext = JUMP; // link first, then jump

            // both traps share the vector fetch
            EXC_OVF,
            EXC_BAD:      stateNext = EXC_WAIT;
            EXC_WAIT:     stateNext = EXC_VEC_READ;
            EXC_VEC_READ: stateNext = EXC_JUMP;
            EXC_JUMP:     stateNext = FETCH;

            MULT_START: stateNext = MULT_WAIT;
            MULT_WAIT:  stateNext = (multCnt == '0) ? MULT_DONE : MULT_WAIT;
            MULT_DONE:  stateNext = FETCH;

            default: stateNext = RESET_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= RESET_INIT;
            multCnt <= '0;
        end else begin
            state <= stateNext;
            if (state == MULT_START) begin
                multCnt <= MULT_LOAD[`MULT_CNT_WIDTH-1:0];
            end else if (state == MULT_WAIT && multCnt != '0) begin
                multCnt <= multCnt - 1'b1;
            end
        end
    end

endmodule

// ==== src/mipsControl.sv ====
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module mipsControl import ctrlPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`OPCODE_WIDTH-1:0] opcode,
    input  logic [`FUNCT_WIDTH-1:0]  funct,
    input  logic                     overflow,
    output logic                     PCWrite,
    output logic                     PCWriteCond,
    output logic                     IRWrite,
    output logic                     MemReadWrite,
    output logic                     RegWrite,
    output logic                     RegALoad,
    output logic                     RegBLoad,
    output logic                     ALUSrcA,
    output logic                     EPCWrite,
    output logic                     ALUOSrc,
    output logic                     ALUOutWrite,
    output logic                     MDRLoad,
    output logic                     HiLoWrite,
    output logic                     multInit,
    output regDst_t                  RegDst,
    output memToReg_t                MemtoReg,
    output aluSrcB_t                 ALUSrcB,
    output iOrD_t                    IorD,
    output aluOp_t                   ALUOp,
    output pcSrc_t                   PCSrc,
    output eqOrNe_t                  EqOrNe
);

    instrClass_t instrClass;
    ctrlState_t  state;

    opDecoder uDecoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    cycleSequencer uSequencer (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state)
    );

    // all datapath controls are a pure function of state
    controlWordGen uWordGen (.*);

endmodule

// ==== src/opDecoder.sv ====
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module opDecoder import ctrlPkg::*; (
    input  logic [`OPCODE_WIDTH-1:0] opcode,
    input  logic [`FUNCT_WIDTH-1:0]  funct,
    output instrClass_t              instrClass
);

    instrClass_t rClass; // meaning of funct under RTYPE

    always_comb begin
        case (funct)
            `FN_ADD: begin
                rClass = CLS_ADD;
            end
            `FN_AND: begin
                rClass = CLS_AND;
            end
            `FN_SUB: begin
                rClass = CLS_SUB;
            end
            `FN_SLT: begin
                rClass = CLS_SLT;
            end
            `FN_JR: begin
                rClass = CLS_JR;
            end
            `FN_MULT: begin
                rClass = CLS_MULT;
            end
            default: begin
                rClass = CLS_INVALID; // unknown funct traps like a bad opcode
            end
        endcase
    end

    always_comb begin
        case (opcode)
            `OP_RTYPE: instrClass = rClass;
            `OP_ADDI:  instrClass = CLS_ADDI;
            `OP_ADDIU: instrClass = CLS_ADDIU;
            `OP_SLTI:  instrClass = CLS_SLTI;
            `OP_LW:    instrClass = CLS_LW;
            `OP_SW:    instrClass = CLS_SW;
            `OP_BEQ:   instrClass = CLS_BEQ;
            `OP_BNE:   instrClass = CLS_BNE;
            `OP_J:     instrClass = CLS_J;
            `OP_JAL:   instrClass = CLS_JAL;
            default:   instrClass = CLS_INVALID;
        endcase
    end

endmodule

// ==== test/ctrlTests.txt ====
# name op fn(ff random unknown) ovf cycles regWr regDst(0rt 1rd 2ra) memToReg(0alu 1mem 6link)
# then epcWr memWr condWr hiLoWr eqOrNe(0 none 1 ne 2 eq)
add           00 20 0  6 1 1 0 0 0 0 0 0
and           00 24 0  6 1 1 0 0 0 0 0 0
sub           00 22 0  6 1 1 0 0 0 0 0 0
slt           00 2a 0  6 1 1 0 0 0 0 0 0
addi          08 00 0  6 1 0 0 0 0 0 0 0
addiu         09 00 0  6 1 0 0 0 0 0 0 0
slti          0a 15 0  6 1 0 0 0 0 0 0 0
addOvf        00 20 1  9 0 0 0 1 0 0 0 0
subOvf        00 22 1  9 0 0 0 1 0 0 0 0
addiOvf       08 00 1  9 0 0 0 1 0 0 0 0
addiuOvf      09 00 1  6 1 0 0 0 0 0 0 0
sltOvfIgnored 00 2a 1  6 1 1 0 0 0 0 0 0
lw            23 00 0  9 1 0 1 0 0 0 0 0
sw            2b 00 0  6 0 0 0 0 1 0 0 0
beq           04 00 0  5 0 0 0 0 0 1 0 2
bne           05 00 0  5 0 0 0 0 0 1 0 1
j             02 00 0  5 0 0 0 0 0 0 0 0
jr            00 08 0  5 0 0 0 0 0 0 0 0
jal           03 00 0  6 1 2 6 0 0 0 0 0
mult          00 18 0 39 0 0 0 0 0 0 1 0
addAfterMult  00 20 0  6 1 1 0 0 0 0 0 0
badOpcode     3f 00 0  8 0 0 0 1 0 0 0 0
badOpcode11   11 20 0  8 0 0 0 1 0 0 0 0
badFunct      00 ff 0  8 0 0 0 1 0 0 0 0
badFunct2     00 ff 1  8 0 0 0 1 0 0 0 0
lwAfterTrap   23 00 0  9 1 0 1 0 0 0 0 0

// ==== test/tbMipsControl.sv ====
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module tbMipsControl import ctrlPkg::*; ();

    typedef struct {
        string name;
        int    opcode, funct, ovf, cycles, regWrites, dst, wb;
        int    epc, memRw, pcCond, hiLo, cmp;
    } testCase_t;

    logic                     clk;
    logic                     rstN;
    logic                     overflow;
    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`FUNCT_WIDTH-1:0]  funct;
    logic PCWrite, PCWriteCond, IRWrite, MemReadWrite, RegWrite, RegALoad, RegBLoad;
    logic ALUSrcA, EPCWrite, ALUOSrc, ALUOutWrite, MDRLoad, HiLoWrite, multInit;
    regDst_t                  RegDst;
    memToReg_t                MemtoReg;
    aluSrcB_t                 ALUSrcB;
    iOrD_t                    IorD;
    aluOp_t                   ALUOp;
    pcSrc_t                   PCSrc;
    eqOrNe_t                  EqOrNe;

    testCase_t tests[$];
    int        errors      = 0;
    int        failedTests = 0;
    int        cycleCount  = 0;
    int        cycleLimit  = 100; // grows with the test file

    mipsControl dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: IRWrite stopped arriving, run aborted after %0d cycles", cycleCount);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic checkInt(string what, int expected, int actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %0d, actual %0d", what, expected, actual);
            errors++;
        end
    endtask

    task automatic checkRegDst(string what, regDst_t expected, regDst_t actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %s, actual %s", what, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic checkMemToReg(string what, memToReg_t expected, memToReg_t actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %s, actual %s", what, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic checkEqOrNe(string what, eqOrNe_t expected, eqOrNe_t actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %s, actual %s", what, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic checkAluSrcB(string what, aluSrcB_t expected, aluSrcB_t actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %s, actual %s", what, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic checkAluOp(string what, aluOp_t expected, aluOp_t actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %s, actual %s", what, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic checkPcSrc(string what, pcSrc_t expected, pcSrc_t actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %s, actual %s", what, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic checkIOrD(string what, iOrD_t expected, iOrD_t actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %s, actual %s", what, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic reportTest(string label, int errorsBefore);
        if (errors == errorsBefore) begin
            $display("ok   %s", label);
        end else begin
            failedTests++;
            $display("bad  %s", label);
        end
    endtask

    // any funct the decoder does not know
    function automatic logic [`FUNCT_WIDTH-1:0] unknownFunct();
        int unsigned             raw;
        logic [`FUNCT_WIDTH-1:0] f;
        do begin
            raw = $urandom;
            f   = raw[`FUNCT_WIDTH-1:0];
        end while (f inside {`FN_ADD, `FN_AND, `FN_SUB, `FN_SLT, `FN_JR, `FN_MULT});
        return f;
    endfunction

    task automatic loadTests();
        int        fd;
        string     line;
        testCase_t t;
        fd = $fopen("test/ctrlTests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file test/ctrlTests.txt");
            errors++;
        end else begin
            void'($fgets(line, fd)); // two column header lines
            void'($fgets(line, fd));
            while ($fscanf(fd, "%s %h %h %d %d %d %d %d %d %d %d %d %d", t.name, t.opcode,
                    t.funct, t.ovf, t.cycles, t.regWrites, t.dst, t.wb, t.epc, t.memRw,
                    t.pcCond, t.hiLo, t.cmp) == 13) begin
                tests.push_back(t);
            end
            $fclose(fd);
        end
        if (tests.size() == 0) begin
            $display("no tests were read from the test file");
            errors++;
        end
    endtask

    initial begin
        int                      cycles;
        int                      regWrites;
        int                      epcWrites;
        int                      memWrites;
        int                      condWrites;
        int                      hiLoWrites;
        int                      multStarts;
        int                      cmpFlags;
        int                      errorsBefore;
        logic                    isCompare;
        regDst_t                 gotDst;
        memToReg_t               gotWb;
        eqOrNe_t                 gotCmp;
        logic [`FUNCT_WIDTH-1:0] fn;

        rstN     = 1'b0;
        opcode   = '0;
        funct    = '0;
        overflow = 1'b0;
        void'($urandom(32'h0b482eed));
        loadTests();
        foreach (tests[i]) begin
            cycleLimit += 2 * tests[i].cycles;
        end

        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        errorsBefore = errors;
        @(posedge clk); // RESET_INIT right after release
        checkInt("reset RegWrite", 1, int'(RegWrite));
        checkRegDst("reset RegDst", DST_SP, RegDst);
        checkMemToReg("reset MemtoReg", WB_SP_INIT, MemtoReg);
        checkInt("reset other strobes", 0, $countones({PCWrite, PCWriteCond, IRWrite,
            MemReadWrite, EPCWrite, ALUOutWrite, RegALoad, RegBLoad, MDRLoad, HiLoWrite,
            multInit}));
        cycles = 1;
        while (!IRWrite) begin
            @(posedge clk);
            cycles++;
        end
        checkInt("reset first IRWrite cycle", 4, cycles); // init, fetch, wait, ir load
        reportTest("reset", errorsBefore);

        foreach (tests[i]) begin
            fn = (tests[i].funct == 'hff) ? unknownFunct() : tests[i].funct[`FUNCT_WIDTH-1:0];
            opcode   <= tests[i].opcode[`OPCODE_WIDTH-1:0]; // ir loads at this edge
            funct    <= fn;
            overflow <= tests[i].ovf[0];
            errorsBefore = errors;
            cycles       = 0;
            regWrites    = 0;
            epcWrites    = 0;
            memWrites    = 0;
            condWrites   = 0;
            hiLoWrites   = 0;
            multStarts   = 0;
            cmpFlags     = 0;
            gotDst       = DST_RT;
            gotWb        = WB_ALU;
            gotCmp       = CMP_NONE;
            do begin
                @(posedge clk);
                cycles++;
                if (RegWrite) begin
                    regWrites++;
                    gotDst = RegDst;
                    gotWb  = MemtoReg;
                end
                if (PCWriteCond) begin
                    condWrites++;
                    gotCmp = EqOrNe;
                end
                if (EPCWrite) epcWrites++;
                if (MemReadWrite) memWrites++;
                if (HiLoWrite) hiLoWrites++;
                if (multInit) multStarts++;
                if (ALUOSrc) cmpFlags++;
                if (cycles == tests[i].cycles - 2) begin // fetch, pc <= pc + 4
                    checkInt({tests[i].name, " fetch PCWrite"}, 1, int'(PCWrite));
                    checkInt({tests[i].name, " fetch ALUSrcA"}, 0, int'(ALUSrcA));
                    checkAluSrcB({tests[i].name, " fetch ALUSrcB"}, SRCB_FOUR, ALUSrcB);
                    checkAluOp({tests[i].name, " fetch ALUOp"}, ALU_ADD, ALUOp);
                    checkPcSrc({tests[i].name, " fetch PCSrc"}, PC_ALU, PCSrc);
                    checkIOrD({tests[i].name, " fetch IorD"}, ADDR_PC, IorD);
                end
            end while (!IRWrite);

            // slt and slti write the compare flag
            isCompare = (tests[i].opcode == `OP_SLTI) ||
                (tests[i].opcode == `OP_RTYPE && fn == `FN_SLT);

            checkInt({tests[i].name, " cycles"}, tests[i].cycles, cycles);
            checkInt({tests[i].name, " RegWrite"}, tests[i].regWrites, regWrites);
            if (tests[i].regWrites > 0) begin
                checkRegDst({tests[i].name, " RegDst"}, regDst_t'(tests[i].dst), gotDst);
                checkMemToReg({tests[i].name, " MemtoReg"}, memToReg_t'(tests[i].wb), gotWb);
            end
            checkInt({tests[i].name, " EPCWrite"}, tests[i].epc, epcWrites);
            checkInt({tests[i].name, " MemReadWrite"}, tests[i].memRw, memWrites);
            checkInt({tests[i].name, " PCWriteCond"}, tests[i].pcCond, condWrites);
            checkInt({tests[i].name, " HiLoWrite"}, tests[i].hiLo, hiLoWrites);
            checkInt({tests[i].name, " multInit"}, tests[i].hiLo, multStarts);
            checkInt({tests[i].name, " ALUOSrc"}, isCompare ? 1 : 0, cmpFlags);
            checkEqOrNe({tests[i].name, " EqOrNe"}, eqOrNe_t'(tests[i].cmp), gotCmp);
            reportTest($sformatf("%s op %h funct %h", tests[i].name,
                tests[i].opcode[`OPCODE_WIDTH-1:0], fn), errorsBefore);
        end

        $display("tests %0d, failed tests %0d, check errors %0d", tests.size() + 1,
            failedTests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
